/* src/fdc_mem_pkg.sv */
package fdc_mem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Memory and datapath widths
	////////////////////////////////////////////////////////////////////////////

	// External SRAM is 512K x 8
	localparam int SRAM_ADDR_W = 19;		// SRAM address bus width

	// Host bus, SRAM data bus and all host registers
	localparam int BYTE_W = 8;

	// Index period, counted in timer ticks
	localparam int INDEX_W = 16;			// Read back as two bytes

endpackage

/* src/fdc_regs_pkg.sv */
package fdc_regs_pkg;
	import fdc_mem_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Host register map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [BYTE_W-1:0] REG_ADDR_LOW      = 8'h00;	// SRAM address [7:0]
	localparam logic [BYTE_W-1:0] REG_ADDR_HIGH     = 8'h01;	// SRAM address [15:8]
	localparam logic [BYTE_W-1:0] REG_ADDR_UPPER    = 8'h02;	// SRAM address [18:16]
	localparam logic [BYTE_W-1:0] REG_SRAM_DATA     = 8'h03;	// SRAM data window
	localparam logic [BYTE_W-1:0] REG_DRIVE_CONTROL = 8'h04;	// Write side only
	localparam logic [BYTE_W-1:0] REG_ID_TYPE_LO    = 8'h04;	// Read side only
	localparam logic [BYTE_W-1:0] REG_ID_TYPE_HI    = 8'h05;
	localparam logic [BYTE_W-1:0] REG_ID_VER_LO     = 8'h06;
	localparam logic [BYTE_W-1:0] REG_ID_VER_HI     = 8'h07;
	localparam logic [BYTE_W-1:0] REG_STATUS1       = 8'h0E;	// Busy, new index measurement
	localparam logic [BYTE_W-1:0] REG_STATUS2       = 8'h0F;	// Drive status lines
	localparam logic [BYTE_W-1:0] REG_SCRATCH       = 8'h30;
	localparam logic [BYTE_W-1:0] REG_SCRATCH_INV   = 8'h31;	// Complement of scratchpad
	localparam logic [BYTE_W-1:0] REG_INDEX_HI      = 8'h40;	// Read this one first
	localparam logic [BYTE_W-1:0] REG_INDEX_LO      = 8'h41;
	localparam logic [BYTE_W-1:0] REG_STEP_RATE     = 8'hF0;
	localparam logic [BYTE_W-1:0] REG_STEP_CMD      = 8'hFF;

	// Identification words
	localparam logic [2*BYTE_W-1:0] MCO_TYPE    = 16'hDD55;
	localparam logic [2*BYTE_W-1:0] MCO_VERSION = 16'h001F;

	// Drive control byte, field view, MSB first
	typedef struct packed {
		logic       side_sel;				// Bit 7
		logic       mot_en;					// Bit 6
		logic [3:0] drv_sel;				// Bits 5..2
		logic       in_use;					// Bit 1
		logic       density;				// Bit 0
	} drive_fields_t;

	// Host writes raw, drive lines read the fields
	typedef union packed {
		logic [BYTE_W-1:0] raw;
		drive_fields_t     f;
	} drive_control_t;

endpackage

/* src/host_port.sv */
module host_port import fdc_regs_pkg::*, fdc_mem_pkg::*; (
	input  logic                   CLK_MASTER,
	input  logic                   reset,
	input  logic [BYTE_W-1:0]      pmd_in,			// Host data bus, inbound
	input  logic                   MCU_PMALL,
	input  logic                   MCU_PMRD,
	input  logic                   MCU_PMWR,
	input  logic [BYTE_W-1:0]      sram_dq_in,
	input  logic [SRAM_ADDR_W-1:0] sram_addr,
	input  logic                   fifo_busy,
	input  logic                   stepping,
	input  logic [INDEX_W-1:0]     period,
	input  logic [BYTE_W-1:0]      period_low,
	input  logic                   new_measure,
	input  logic                   index_in,		// Raw drive status lines
	input  logic                   track0_in,
	input  logic                   wrprot_in,
	input  logic                   ready_in,
	input  logic                   dens_in,
	output logic [BYTE_W-1:0]      pmd_out,
	output logic                   push,
	output logic [BYTE_W-1:0]      push_data,
	output logic                   load_low,
	output logic                   load_high,
	output logic                   load_upper,
	output logic [BYTE_W-1:0]      load_data,
	output logic                   rd_done,
	output logic                   step_cmd,
	output logic [BYTE_W-1:0]      step_byte,
	output logic                   index_hi_read,
	output logic [BYTE_W-1:0]      step_rate,
	output drive_control_t         drive_ctrl
);

	logic [BYTE_W-1:0] addr_q;				// Latched register address
	logic [2:0]        wr_sync;				// Two sync flops plus edge history
	logic [2:0]        rd_sync;
	logic              wr_pulse;
	logic              rd_rise;
	logic              rd_fall;
	logic [BYTE_W-1:0] scratch;
	logic [BYTE_W-1:0] dq_lat;				// SRAM byte held for the host read

	////////////////////////////////////////////////////////////////////////////
	// Address latch and strobe synchronisers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			addr_q  <= '0;
			wr_sync <= '0;
			rd_sync <= '0;
		end else begin
			if (MCU_PMALL)
				addr_q <= pmd_in;			// Transparent while ALE high
			wr_sync <= {wr_sync[1:0], MCU_PMWR};
			rd_sync <= {rd_sync[1:0], MCU_PMRD};
		end
	end

	assign wr_pulse = wr_sync[1] & ~wr_sync[2];		// One cycle per write strobe
	assign rd_rise  = rd_sync[1] & ~rd_sync[2];
	assign rd_fall  = ~rd_sync[1] & rd_sync[2];

	// Track the SRAM output until the synchronised read strobe arrives
	always_ff @(posedge CLK_MASTER) begin
		if (!rd_sync[1])
			dq_lat <= sram_dq_in;
	end

	////////////////////////////////////////////////////////////////////////////
	// Register writes and command pulses
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			drive_ctrl <= '0;				// All drive lines inactive
			scratch    <= '0;
			step_rate  <= '0;
		end else if (wr_pulse) begin
			case (addr_q)
				REG_DRIVE_CONTROL: drive_ctrl.raw <= pmd_in;
				REG_SCRATCH:       scratch        <= pmd_in;
				REG_STEP_RATE:     step_rate      <= pmd_in;
				default: ;
			endcase
		end
	end

	assign push       = wr_pulse && (addr_q == REG_SRAM_DATA);
	assign load_low   = wr_pulse && (addr_q == REG_ADDR_LOW);
	assign load_high  = wr_pulse && (addr_q == REG_ADDR_HIGH);
	assign load_upper = wr_pulse && (addr_q == REG_ADDR_UPPER);
	assign step_cmd   = wr_pulse && (addr_q == REG_STEP_CMD);
	assign push_data  = pmd_in;			// Bus still held by the host here
	assign load_data  = pmd_in;
	assign step_byte  = pmd_in;

	// Read side effects
	assign rd_done       = rd_fall && (addr_q == REG_SRAM_DATA);	// Advance after the byte
	assign index_hi_read = rd_rise && (addr_q == REG_INDEX_HI);	// Freeze low byte

	////////////////////////////////////////////////////////////////////////////
	// Readback multiplexer
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (addr_q)
			REG_ADDR_LOW:    pmd_out = sram_addr[7:0];
			REG_ADDR_HIGH:   pmd_out = sram_addr[15:8];
			REG_ADDR_UPPER:  pmd_out = {{(BYTE_W-SRAM_ADDR_W+16){1'b0}},
						sram_addr[SRAM_ADDR_W-1:16]};
			REG_SRAM_DATA:   pmd_out = dq_lat;
			REG_ID_TYPE_LO:  pmd_out = MCO_TYPE[7:0];
			REG_ID_TYPE_HI:  pmd_out = MCO_TYPE[15:8];
			REG_ID_VER_LO:   pmd_out = MCO_VERSION[7:0];
			REG_ID_VER_HI:   pmd_out = MCO_VERSION[15:8];
			REG_STATUS1:     pmd_out = {{(BYTE_W-2){1'b0}}, new_measure, fifo_busy};
			REG_STATUS2:     pmd_out = {index_in, track0_in, wrprot_in, ready_in,
						dens_in, stepping, 2'b00};
			REG_SCRATCH:     pmd_out = scratch;
			REG_SCRATCH_INV: pmd_out = ~scratch;			// Bus stuck-bit check
			REG_INDEX_HI:    pmd_out = period[15:8];
			REG_INDEX_LO:    pmd_out = period_low;
			REG_STEP_RATE:   pmd_out = step_rate;
			default:         pmd_out = '0;
		endcase
	end

	// Host never overlaps a read and a write strobe
	assert property (@(posedge CLK_MASTER) disable iff (reset)
		!(wr_pulse && (rd_rise || rd_fall)));

endmodule

/* src/sram_writer.sv */
module sram_writer import fdc_mem_pkg::*; #(
	parameter int FIFO_DEPTH = 16		// Power of two
) (
	input  logic              CLK_MASTER,
	input  logic              reset,
	input  logic              push,
	input  logic [BYTE_W-1:0] push_data,
	output logic [BYTE_W-1:0] wr_data,		// Driven onto SRAM_DQ while OE is off
	output logic              we_n,
	output logic              oe_n,
	output logic              addr_inc,
	output logic              busy
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	// Write cycle states
	localparam logic [2:0] S_IDLE      = 3'd0;	// SRAM outputs on, waiting for data
	localparam logic [2:0] S_OE_OFF    = 3'd1;	// Release the bus, pop a byte
	localparam logic [2:0] S_WRITE     = 3'd2;	// WE low
	localparam logic [2:0] S_WRITE_END = 3'd3;
	localparam logic [2:0] S_INC_ADDR  = 3'd4;

	logic [BYTE_W-1:0] fifo_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    count;
	logic              full;
	logic              empty;
	logic              do_push;
	logic              do_pop;
	logic [2:0]        state;

	assign full    = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;			// Dropped when full
	assign do_pop  = (state == S_IDLE) && !empty;
	assign busy    = !empty || (state != S_IDLE);

	always_ff @(posedge CLK_MASTER) begin
		if (do_push)
			fifo_mem[wr_ptr] <= push_data;
		if (do_pop)
			wr_data <= fifo_mem[rd_ptr];		// Valid from OE-off onwards
	end

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Write state machine, five cycles per byte
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			state    <= S_IDLE;
			we_n     <= 1'b1;
			oe_n     <= 1'b0;				// SRAM drives DQ for host reads
			addr_inc <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (do_pop) begin
						oe_n  <= 1'b1;
						state <= S_OE_OFF;
					end
				end
				S_OE_OFF: begin
					we_n  <= 1'b0;			// Data already on the bus
					state <= S_WRITE;
				end
				S_WRITE: begin
					we_n  <= 1'b1;			// Rising WE commits the byte
					state <= S_WRITE_END;
				end
				S_WRITE_END: begin
					addr_inc <= 1'b1;
					state    <= S_INC_ADDR;
				end
				S_INC_ADDR: begin
					addr_inc <= 1'b0;
					oe_n     <= 1'b0;
					state    <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Bus released a cycle before WE falls, so no contention
	assert property (@(posedge CLK_MASTER) disable iff (reset)
		!we_n |-> oe_n && $past(oe_n));

	// A write cycle only starts with a byte in the FIFO
	assert property (@(posedge CLK_MASTER) disable iff (reset)
		(state == S_OE_OFF) |-> $past(count) != '0);

endmodule

/* src/sram_addr_counter.sv */
module sram_addr_counter import fdc_mem_pkg::*; (
	input  logic                   CLK_MASTER,
	input  logic                   reset,
	input  logic                   load_low,
	input  logic                   load_high,
	input  logic                   load_upper,
	input  logic [BYTE_W-1:0]      load_data,
	input  logic                   addr_inc,		// From the write machine
	input  logic                   rd_done,		// From a host SRAM read
	output logic [SRAM_ADDR_W-1:0] addr
);

	logic inc_req;

	assign inc_req = addr_inc || rd_done;		// Both at once count as one

	always_ff @(posedge CLK_MASTER) begin
		if (reset)
			addr <= '0;
		else if (load_low)						// Loads beat increments
			addr[7:0] <= load_data;
		else if (load_high)
			addr[15:8] <= load_data;
		else if (load_upper)
			addr[SRAM_ADDR_W-1:16] <= load_data[SRAM_ADDR_W-17:0];	// 3 bits only
		else if (inc_req)
			addr <= addr + 1'b1;				// Wraps at the top of SRAM
	end

	// No increment rides along with a load, bytes outside the load hold
	assert property (@(posedge CLK_MASTER) disable iff (reset)
		(load_high || load_upper) |=> addr[7:0] == $past(addr[7:0]));

	assert property (@(posedge CLK_MASTER) disable iff (reset)
		load_low |=> addr[SRAM_ADDR_W-1:8] == $past(addr[SRAM_ADDR_W-1:8]));

endmodule

/* src/head_stepper.sv */
module head_stepper import fdc_mem_pkg::*; #(
	parameter int STEP_TICK_CYCLES = 25000		// Clocks per step tick
) (
	input  logic              CLK_MASTER,
	input  logic              reset,
	input  logic [BYTE_W-1:0] step_rate,		// Ticks per step, minus one
	input  logic              step_cmd,
	input  logic [BYTE_W-1:0] step_byte,		// Direction and count
	input  logic              track0_n,
	output logic              step_n,
	output logic              dir,				// High is outward
	output logic              stepping
);

	localparam int TICK_W = $clog2(STEP_TICK_CYCLES + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	logic [BYTE_W-1:0] rate_cnt;
	logic              slot;				// Step opportunity
	logic [6:0]        remaining;
	logic [1:0]        trk0_sync;			// Drive line is asynchronous

	assign tick = (tick_cnt == TICK_W'(STEP_TICK_CYCLES - 1));
	assign slot = tick && (rate_cnt >= step_rate);

	// Tick divider and step-rate divider, free running
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			tick_cnt  <= '0;
			rate_cnt  <= '0;
			trk0_sync <= 2'b11;
		end else begin
			trk0_sync <= {trk0_sync[0], track0_n};
			tick_cnt  <= tick ? '0 : tick_cnt + 1'b1;
			if (slot)
				rate_cnt <= '0;
			else if (tick)
				rate_cnt <= rate_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Step pulse sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			step_n    <= 1'b1;
			dir       <= 1'b1;
			stepping  <= 1'b0;
			remaining <= '0;
		end else if (!stepping) begin
			if (step_cmd && (step_byte[6:0] != '0)) begin	// Busy commands are ignored
				stepping  <= 1'b1;
				remaining <= step_byte[6:0];
				dir       <= ~step_byte[7];		// Inward drives DIR low
			end
		end else if (tick && !step_n) begin
			step_n <= 1'b1;					// Pulse lasts one tick
		end else if (slot) begin
			if ((remaining == '0) || (dir && !trk0_sync[1])) begin
				stepping  <= 1'b0;			// Done, or parked on track 0
				remaining <= '0;
			end else begin
				step_n    <= 1'b0;
				remaining <= remaining - 1'b1;
			end
		end
	end

endmodule

/* src/index_timer.sv */
module index_timer import fdc_mem_pkg::*; #(
	parameter int INDEX_TICK_CYCLES = 1000		// Clocks per period tick
) (
	input  logic               CLK_MASTER,
	input  logic               reset,
	input  logic               index_in,
	input  logic               index_hi_read,
	output logic [INDEX_W-1:0] period,
	output logic [BYTE_W-1:0]  period_low,
	output logic               new_measure
);

	localparam int TICK_W = $clog2(INDEX_TICK_CYCLES + 1);

	logic [2:0]         idx_sync;			// Two sync flops and edge history
	logic               idx_edge;
	logic [TICK_W-1:0]  tick_cnt;
	logic               tick;
	logic [INDEX_W-1:0] count;			// Ticks since the last index

	assign idx_edge = idx_sync[1] & ~idx_sync[2];
	assign tick     = (tick_cnt == TICK_W'(INDEX_TICK_CYCLES - 1));

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			idx_sync    <= '0;
			tick_cnt    <= '0;
			count       <= '0;
			period      <= '0;
			period_low  <= '0;
			new_measure <= 1'b0;
		end else begin
			idx_sync <= {idx_sync[1:0], index_in};
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (idx_edge) begin
				period <= count;		// One revolution measured
				count  <= '0;
			end else if (tick) begin
				count <= count + 1'b1;
			end
			// Low byte frozen so a HI then LO read pair is coherent
			if (index_hi_read)
				period_low <= period[7:0];
			if (index_hi_read)
				new_measure <= 1'b0;		// Read wins over a new edge
			else if (idx_edge)
				new_measure <= 1'b1;
		end
	end

endmodule

/* src/fdc_top.sv */
module fdc_top import fdc_regs_pkg::*, fdc_mem_pkg::*; #(
	parameter int FIFO_DEPTH        = 16,
	parameter int STEP_TICK_CYCLES  = 25000,	// 250 us at 100 MHz
	parameter int INDEX_TICK_CYCLES = 1000		// 10 us at 100 MHz
) (
	input  logic                   CLK_MASTER,
	input  logic                   reset,
	inout  wire  [BYTE_W-1:0]      MCU_PMD,
	input  logic                   MCU_PMALL,
	input  logic                   MCU_PMRD,
	input  logic                   MCU_PMWR,
	output logic [SRAM_ADDR_W-1:0] SRAM_A,
	inout  wire  [BYTE_W-1:0]      SRAM_DQ,
	output logic                   SRAM_WE_n,
	output logic                   SRAM_OE_n,
	output logic                   SRAM_CE_n,
	output logic                   FD_DENS_OUT,
	output logic                   FD_INUSE,
	output logic                   FD_MOTEN,
	output logic                   FD_SIDESEL,
	output logic                   FD_STEP,
	output logic                   FD_DIR,
	output logic [3:0]             FD_DRVSEL,
	input  logic                   FD_INDEX_IN,
	input  logic                   FD_TRACK0_IN,
	input  logic                   FD_WRPROT_IN,
	input  logic                   FD_RDY_DCHG_IN,
	input  logic                   FD_DENS_IN
);

	logic [BYTE_W-1:0]  pmd_out, push_data, load_data, step_byte, step_rate, wr_data;
	logic [BYTE_W-1:0]  period_low;
	logic [INDEX_W-1:0] period;
	logic               push, load_low, load_high, load_upper, rd_done, step_cmd;
	logic               index_hi_read, addr_inc, fifo_busy, stepping, new_measure;
	drive_control_t     drive_ctrl;

	////////////////////////////////////////////////////////////////////////////
	// Bus buffers and drive lines
	////////////////////////////////////////////////////////////////////////////

	assign MCU_PMD   = MCU_PMRD ? pmd_out : 'z;	// Host owns the bus unless reading
	assign SRAM_DQ   = SRAM_OE_n ? wr_data : 'z;
	assign SRAM_CE_n = 1'b0;				// Always selected

	// Drive lines are active low
	assign FD_DENS_OUT = ~drive_ctrl.f.density;
	assign FD_INUSE    = ~drive_ctrl.f.in_use;
	assign FD_DRVSEL   = ~drive_ctrl.f.drv_sel;
	assign FD_MOTEN    = ~drive_ctrl.f.mot_en;
	assign FD_SIDESEL  = ~drive_ctrl.f.side_sel;

	host_port u_host_port (
		.CLK_MASTER, .reset, .pmd_in(MCU_PMD), .MCU_PMALL, .MCU_PMRD, .MCU_PMWR,
		.sram_dq_in(SRAM_DQ), .sram_addr(SRAM_A), .fifo_busy, .stepping, .period,
		.period_low, .new_measure, .index_in(FD_INDEX_IN), .track0_in(FD_TRACK0_IN),
		.wrprot_in(FD_WRPROT_IN), .ready_in(FD_RDY_DCHG_IN), .dens_in(FD_DENS_IN),
		.pmd_out, .push, .push_data, .load_low, .load_high, .load_upper, .load_data,
		.rd_done, .step_cmd, .step_byte, .index_hi_read, .step_rate, .drive_ctrl);

	sram_writer #(.FIFO_DEPTH(FIFO_DEPTH)) u_sram_writer (
		.CLK_MASTER, .reset, .push, .push_data, .wr_data, .we_n(SRAM_WE_n),
		.oe_n(SRAM_OE_n), .addr_inc, .busy(fifo_busy));

	sram_addr_counter u_sram_addr_counter (
		.CLK_MASTER, .reset, .load_low, .load_high, .load_upper, .load_data,
		.addr_inc, .rd_done, .addr(SRAM_A));

	head_stepper #(.STEP_TICK_CYCLES(STEP_TICK_CYCLES)) u_head_stepper (
		.CLK_MASTER, .reset, .step_rate, .step_cmd, .step_byte,
		.track0_n(FD_TRACK0_IN), .step_n(FD_STEP), .dir(FD_DIR), .stepping);

	index_timer #(.INDEX_TICK_CYCLES(INDEX_TICK_CYCLES)) u_index_timer (
		.CLK_MASTER, .reset, .index_in(FD_INDEX_IN), .index_hi_read, .period,
		.period_low, .new_measure);

endmodule

/* test/tb_fdc_top.sv */
module tb_fdc_top import fdc_regs_pkg::*, fdc_mem_pkg::*; ();

	localparam int FIFO_DEPTH = 16;
	localparam int STEP_TICK  = 20;			// Clocks per step tick
	localparam int INDEX_TICK = 10;			// Clocks per index tick
	localparam int NUM_SRAM   = 12;
	localparam int NUM_DRIVE  = 8;
	localparam int NUM_STEP   = 6;			// Random step commands
	localparam int NUM_INDEX  = 5;

	// Bus cycle lengths, latch phase included
	localparam int WR_CYC       = 12;
	localparam int RD_CYC       = 9;
	localparam int STEP_CMD_CYC = WR_CYC + 2*RD_CYC + 9*2*STEP_TICK;
	localparam int T_RESET      = 10 + WR_CYC + 6*RD_CYC;
	localparam int T_SRAM_WR    = 15*WR_CYC + 6*RD_CYC;
	localparam int T_SRAM_RD    = 3*WR_CYC + 13*RD_CYC;
	localparam int T_DRIVE      = NUM_DRIVE*WR_CYC;
	localparam int T_STEP       = WR_CYC + (2*NUM_STEP + 2)*STEP_CMD_CYC;
	localparam int T_INDEX      = NUM_INDEX*(2*4*10*INDEX_TICK + 20 + 4*RD_CYC);
	localparam int TOTAL_CYC    = T_RESET + T_SRAM_WR + T_SRAM_RD + T_DRIVE + T_STEP + T_INDEX;

	logic                   CLK_MASTER = 1'b0;
	logic                   reset;
	logic [BYTE_W-1:0]      host_pmd;		// Host side of the shared bus
	logic                   MCU_PMALL, MCU_PMRD, MCU_PMWR;
	wire  [BYTE_W-1:0]      MCU_PMD;
	wire  [BYTE_W-1:0]      SRAM_DQ;
	logic [SRAM_ADDR_W-1:0] SRAM_A;
	logic                   SRAM_WE_n, SRAM_OE_n, SRAM_CE_n;
	logic                   FD_DENS_OUT, FD_INUSE, FD_MOTEN, FD_SIDESEL, FD_STEP, FD_DIR;
	logic [3:0]             FD_DRVSEL;
	logic                   FD_INDEX_IN, FD_TRACK0_IN, FD_WRPROT_IN, FD_RDY_DCHG_IN, FD_DENS_IN;

	logic [BYTE_W-1:0] sram_mem [2**SRAM_ADDR_W];		// External SRAM model
	int                track = 3;					// Drive head position
	int                in_cnt, out_cnt;				// Step pulses per direction
	integer            seed;
	string             test_name;

	always #50 CLK_MASTER = ~CLK_MASTER;

	fdc_top #(.FIFO_DEPTH(FIFO_DEPTH), .STEP_TICK_CYCLES(STEP_TICK),
		.INDEX_TICK_CYCLES(INDEX_TICK)) u_fdc_top (
		.CLK_MASTER, .reset, .MCU_PMD, .MCU_PMALL, .MCU_PMRD, .MCU_PMWR, .SRAM_A,
		.SRAM_DQ, .SRAM_WE_n, .SRAM_OE_n, .SRAM_CE_n, .FD_DENS_OUT, .FD_INUSE,
		.FD_MOTEN, .FD_SIDESEL, .FD_STEP, .FD_DIR, .FD_DRVSEL, .FD_INDEX_IN,
		.FD_TRACK0_IN, .FD_WRPROT_IN, .FD_RDY_DCHG_IN, .FD_DENS_IN);

	////////////////////////////////////////////////////////////////////////////
	// Bus, SRAM and drive models
	////////////////////////////////////////////////////////////////////////////

	assign MCU_PMD      = MCU_PMRD ? 'z : host_pmd;		// DUT owns it during reads
	assign SRAM_DQ      = SRAM_OE_n ? 'z : sram_mem[SRAM_A];
	assign FD_TRACK0_IN = (track != 0);					// Low at track 0

	// Byte committed on the rising WE edge
	always @(posedge SRAM_WE_n) begin
		if (!reset)
			sram_mem[SRAM_A] = SRAM_DQ;
	end

	always @(negedge FD_STEP) begin
		if (!reset) begin
			if (FD_DIR) begin				// Outward
				out_cnt++;
				if (track > 0)
					track--;
			end else begin
				in_cnt++;
				track++;
			end
		end
	end

	// Hang guard sized from the test lengths
	initial begin
		#(2 * TOTAL_CYC * 100);
		$display("watchdog expired before all tests completed");
		$display("test failed");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string what, input logic [BYTE_W-1:0] exp,
		input logic [BYTE_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s %s expected %02h actual %02h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_addr(input string what, input logic [SRAM_ADDR_W-1:0] exp,
		input logic [SRAM_ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s %s expected %05h actual %05h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	// Pins are active low copies of the control byte bits
	task automatic check_drive(input string what, input drive_control_t exp);
		logic [BYTE_W-1:0] want, got;
		want = ~exp.raw;				// Side 7, motor 6, select 5..2, in-use 1, density 0
		got  = {FD_SIDESEL, FD_MOTEN, FD_DRVSEL, FD_INUSE, FD_DENS_OUT};
		if (got !== want) begin
			$display("mismatch %s %s expected %02h actual %02h", test_name, what, want,
				got);
			abort_run();
		end
	endtask

	// One tick of slack either way
	task automatic check_period(input string what, input int exp,
		input logic [INDEX_W-1:0] act);
		if ($isunknown(act) || (int'(act) > exp + 1) || (int'(act) + 1 < exp)) begin
			$display("mismatch %s %s expected %0d actual %0d", test_name, what, exp, act);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK_MASTER);
		#10;							// Drive point after the edge
	endtask

	task automatic latch_addr(input logic [BYTE_W-1:0] a);
		host_pmd  = a;
		MCU_PMALL = 1'b1;
		wait_cycles(2);
		MCU_PMALL = 1'b0;
	endtask

	task automatic bus_write(input logic [BYTE_W-1:0] a, input logic [BYTE_W-1:0] d);
		latch_addr(a);
		host_pmd = d;
		MCU_PMWR = 1'b1;
		wait_cycles(6);
		MCU_PMWR = 1'b0;
		host_pmd = '0;
		wait_cycles(4);
	endtask

	task automatic bus_read(input logic [BYTE_W-1:0] a, output logic [BYTE_W-1:0] d);
		latch_addr(a);
		MCU_PMRD = 1'b1;
		wait_cycles(3);
		d = MCU_PMD;
		MCU_PMRD = 1'b0;
		wait_cycles(4);					// Falling strobe may advance the address
	endtask

	task automatic load_addr(input logic [SRAM_ADDR_W-1:0] a, input logic [BYTE_W-1:0] junk);
		bus_write(REG_ADDR_LOW, a[7:0]);
		bus_write(REG_ADDR_HIGH, a[15:8]);
		bus_write(REG_ADDR_UPPER, {junk[7:3], a[18:16]});	// Junk above bit 2
	endtask

	task automatic read_addr(output logic [SRAM_ADDR_W-1:0] a);
		logic [BYTE_W-1:0] lo, hi, up;
		bus_read(REG_ADDR_LOW, lo);
		bus_read(REG_ADDR_HIGH, hi);
		bus_read(REG_ADDR_UPPER, up);
		a = {up[2:0], hi, lo};
	endtask

	// One step command, then wait for the stepper to go idle
	task automatic step_and_check(input logic inward, input int count);
		int                exp_in, exp_out, exp_track;
		logic [BYTE_W-1:0] st;
		exp_in    = inward ? count : 0;
		exp_out   = inward ? 0 : ((count < track) ? count : track);	// Stops at track 0
		exp_track = inward ? track + count : track - exp_out;
		in_cnt    = 0;
		out_cnt   = 0;
		bus_write(REG_STEP_CMD, {inward, 7'(count)});
		do
			bus_read(REG_STATUS2, st);
		while (st[2]);
		check_byte("inward pulses", 8'(exp_in), 8'(in_cnt));
		check_byte("outward pulses", 8'(exp_out), 8'(out_cnt));
		check_byte("track", 8'(exp_track), 8'(track));
		check_byte("status2", {1'b0, exp_track != 0, FD_WRPROT_IN, FD_RDY_DCHG_IN,
			FD_DENS_IN, 3'b000}, st);
	endtask

	task automatic index_pair(input int spacing);
		FD_INDEX_IN = 1'b1;
		wait_cycles(5);
		FD_INDEX_IN = 1'b0;
		wait_cycles(spacing - 5);
		FD_INDEX_IN = 1'b1;				// Closes the measured revolution
		wait_cycles(5);
		FD_INDEX_IN = 1'b0;
		wait_cycles(5);					// Period latched by now
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [BYTE_W-1:0]      rd, hi, lo, scratch, junk;
		logic [BYTE_W-1:0]      wr_bytes [NUM_SRAM];
		logic [SRAM_ADDR_W-1:0] start, got_addr;
		drive_control_t         exp_drive;
		int                     n;

		seed           = 33959;
		reset          = 1'b1;
		host_pmd       = '0;
		MCU_PMALL      = 1'b0;
		MCU_PMRD       = 1'b0;
		MCU_PMWR       = 1'b0;
		FD_INDEX_IN    = 1'b0;
		FD_WRPROT_IN   = $random(seed);		// Static drive status lines
		FD_RDY_DCHG_IN = $random(seed);
		FD_DENS_IN     = $random(seed);
		wait_cycles(8);
		reset = 1'b0;
		wait_cycles(2);

		test_name     = "reset_state";
		exp_drive.raw = '0;
		check_drive("drive lines", exp_drive);
		check_byte("control pins", 8'h0E, {3'b000, SRAM_CE_n, FD_STEP, FD_DIR, SRAM_WE_n,
			SRAM_OE_n});
		bus_read(REG_ID_TYPE_LO, rd);
		check_byte("type low", 8'h55, rd);
		bus_read(REG_ID_TYPE_HI, rd);
		check_byte("type high", 8'hDD, rd);
		bus_read(REG_ID_VER_LO, rd);
		check_byte("version low", 8'h1F, rd);
		bus_read(REG_ID_VER_HI, rd);
		check_byte("version high", 8'h00, rd);
		scratch = $random(seed);
		bus_write(REG_SCRATCH, scratch);
		bus_read(REG_SCRATCH, rd);
		check_byte("scratch", scratch, rd);
		bus_read(REG_SCRATCH_INV, rd);
		check_byte("scratch inverse", ~scratch, rd);

		test_name = "sram_write";
		start     = $random(seed);
		junk      = $random(seed);
		load_addr(start, junk);
		read_addr(got_addr);
		check_addr("loaded address", start, got_addr);
		for (int i = 0; i < NUM_SRAM; i++) begin
			wr_bytes[i] = $random(seed);
			bus_write(REG_SRAM_DATA, wr_bytes[i]);
		end
		read_addr(got_addr);
		check_addr("final address", start + SRAM_ADDR_W'(NUM_SRAM), got_addr);
		for (int i = 0; i < NUM_SRAM; i++)
			check_byte($sformatf("byte %0d", i), wr_bytes[i],
				sram_mem[start + SRAM_ADDR_W'(i)]);

		test_name = "sram_read";
		load_addr(start, junk);
		for (int i = 0; i < NUM_SRAM; i++) begin
			bus_read(REG_SRAM_DATA, rd);
			check_byte($sformatf("byte %0d", i), wr_bytes[i], rd);
		end
		bus_read(REG_STATUS1, rd);
		check_byte("status1", 8'h00, rd);		// FIFO drained, no index yet

		test_name = "drive_control";
		for (int i = 0; i < NUM_DRIVE; i++) begin
			exp_drive.raw = $random(seed);
			bus_write(REG_DRIVE_CONTROL, exp_drive.raw);
			check_drive($sformatf("write %0d", i), exp_drive);
		end

		test_name = "stepping";
		bus_write(REG_STEP_RATE, 8'd1);		// Two ticks per step
		for (int i = 0; i < NUM_STEP; i++) begin
			n = 1 + {$random(seed)} % 6;
			step_and_check($random(seed), n);
		end
		while (track != 0)
			step_and_check(1'b0, 6);
		step_and_check(1'b0, 3);			// Already parked, no pulses

		test_name = "index_period";
		for (int i = 0; i < NUM_INDEX; i++) begin
			n = 1 + {$random(seed)} % 4;
			index_pair(n * 10 * INDEX_TICK);
			bus_read(REG_STATUS1, rd);
			check_byte("status1 before read", 8'h02, rd);
			bus_read(REG_INDEX_HI, hi);
			bus_read(REG_INDEX_LO, lo);
			check_period("period", n * 10, {hi, lo});
			bus_read(REG_STATUS1, rd);
			check_byte("status1 after read", 8'h00, rd);
		end

		$display("test passed");
		$finish;
	end

endmodule

/* verilog.f */
src/fdc_mem_pkg.sv
src/fdc_regs_pkg.sv
src/host_port.sv
src/sram_writer.sv
src/sram_addr_counter.sv
src/head_stepper.sv
src/index_timer.sv
src/fdc_top.sv
test/tb_fdc_top.sv

/* Bender.yml */
package:
  name: fdc_core

sources:
  - src/fdc_mem_pkg.sv
  - src/fdc_regs_pkg.sv
  - src/host_port.sv
  - src/sram_writer.sv
  - src/sram_addr_counter.sv
  - src/head_stepper.sv
  - src/index_timer.sv
  - src/fdc_top.sv
  - target: test
    files:
      - test/tb_fdc_top.sv
